// ==== verilog/i2c_standby_pkg.sv ====
// Queue and descriptor widths, target address, synchronizer depth, fill byte and shared types

package i2c_standby_pkg;

  // Every TTI queue carries the same word
  localparam int unsigned TtiDataWidth = 32;

  // Byte count field in the low bits of both descriptors
  localparam int unsigned DescLenWidth = 16;

  // Input synchronizer depth for SCL and SDA
  localparam int unsigned SyncStages = 2;

  // Fixed 7-bit standby address
  localparam logic [6:0] TargetAddr = 7'h0C;

  typedef logic [TtiDataWidth-1:0] tti_word_t;
  typedef logic [7:0] i2c_byte_t;
  typedef logic [DescLenWidth-1:0] desc_len_t;

  // Served once the TX byte count is used up
  localparam i2c_byte_t FillByte = 8'hFF;

endpackage

// ==== verilog/i2c_bus_monitor.sv ====
// SCL/SDA input synchronizer with SCL edge, START and STOP strobes
`timescale 1ns/1ps

module i2c_bus_monitor (
  input  logic clk_i,
  input  logic arst_n_i,
  input  logic scl_i,
  input  logic sda_i,
  output logic sda_o,
  output logic scl_rise_o,
  output logic scl_fall_o,
  output logic start_o,
  output logic stop_o
);

  import i2c_standby_pkg::*;

  logic [SyncStages-1:0] scl_sync_q;
  logic [SyncStages-1:0] sda_sync_q;
  logic scl_s;
  logic sda_s;
  logic scl_prev_q;
  logic sda_prev_q;

  assign scl_s = scl_sync_q[SyncStages-1];
  assign sda_s = sda_sync_q[SyncStages-1];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      // Idle bus is high
      scl_sync_q <= '1;
      sda_sync_q <= '1;
      scl_prev_q <= 1'b1;
      sda_prev_q <= 1'b1;
      sda_o      <= 1'b1;
      scl_rise_o <= 1'b0;
      scl_fall_o <= 1'b0;
      start_o    <= 1'b0;
      stop_o     <= 1'b0;
    end else begin
      scl_sync_q <= {scl_sync_q[SyncStages-2:0], scl_i};
      sda_sync_q <= {sda_sync_q[SyncStages-2:0], sda_i};
      scl_prev_q <= scl_s;
      sda_prev_q <= sda_s;
      sda_o      <= sda_s;
      scl_rise_o <= scl_s & ~scl_prev_q;
      scl_fall_o <= ~scl_s & scl_prev_q;
      // SDA moving while SCL stays high
      start_o    <= scl_s & scl_prev_q & sda_prev_q & ~sda_s;
      stop_o     <= scl_s & scl_prev_q & ~sda_prev_q & sda_s;
    end
  end

endmodule

// ==== verilog/i2c_byte_shifter.sv ====
// Receive and transmit shift registers with address match and direction bit
`timescale 1ns/1ps

module i2c_byte_shifter (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  logic                      shift_en_i,
  input  logic                      sda_i,
  input  logic                      load_i,
  input  i2c_standby_pkg::i2c_byte_t tx_byte_i,
  output i2c_standby_pkg::i2c_byte_t rx_byte_o,
  output logic                      addr_match_o,
  output logic                      read_bit_o,
  output logic                      tx_bit_o
);

  import i2c_standby_pkg::*;

  i2c_byte_t rx_sr_q;
  i2c_byte_t tx_sr_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rx_sr_q <= '0;
      tx_sr_q <= '1;
    end else begin
      // MSB first in both directions
      if (shift_en_i) begin
        rx_sr_q <= {rx_sr_q[6:0], sda_i};
      end
      if (load_i) begin
        tx_sr_q <= tx_byte_i;
      end else if (shift_en_i) begin
        tx_sr_q <= {tx_sr_q[6:0], 1'b1};
      end
    end
  end

  assign rx_byte_o    = rx_sr_q;
  assign addr_match_o = (rx_sr_q[7:1] == TargetAddr);
  assign read_bit_o   = rx_sr_q[0];
  assign tx_bit_o     = tx_sr_q[7];

endmodule

// ==== verilog/i2c_target_fsm.sv ====
// Target control FSM for address, data, ACK/NACK, SCL stretching and transfer end
`timescale 1ns/1ps

module i2c_target_fsm (
  input  logic clk_i,
  input  logic arst_n_i,
  input  logic enable_i,
  input  logic sda_i,
  input  logic scl_rise_i,
  input  logic scl_fall_i,
  input  logic start_i,
  input  logic stop_i,
  input  logic addr_match_i,
  input  logic read_bit_i,
  input  logic tx_bit_i,
  input  logic byte_ready_i,
  input  logic tx_byte_valid_i,
  input  logic host_ack_i,
  output logic scl_o,
  output logic sda_o,
  output logic shift_en_o,
  output logic load_tx_o,
  output logic byte_valid_o,
  output logic end_xfer_o,
  output logic start_read_o,
  output logic byte_req_o,
  output logic end_read_o
);

  typedef enum logic [2:0] {
    StIdle,
    StAddr,
    StAddrAck,
    StWrData,
    StWrAck,
    StRdData,
    StRdAck
  } state_e;

  state_e     state_q;
  logic [2:0] bit_cnt_q;
  logic       byte_done_q;
  logic       byte_pend_q;
  logic       load_pend_q;
  logic       host_ack_q;
  logic       wr_xfer_q;
  logic       rd_xfer_q;
  logic       stretch_q;
  logic       xfer_break;
  logic       addr_ok;
  logic       rd_nack;
  logic       rd_lost;
  logic       take_byte;
  logic       scl_hold;

  assign xfer_break = start_i | stop_i;
  assign addr_ok = (state_q == StAddr) && scl_fall_i && byte_done_q &&
                   addr_match_i && enable_i;
  assign rd_nack = (state_q == StRdAck) && scl_fall_i && !host_ack_q;
  // Released bit read back low, someone else owns SDA
  assign rd_lost = (state_q == StRdData) && !load_pend_q && scl_rise_i && tx_bit_i && !sda_i;
  assign take_byte = (state_q == StRdData) && load_pend_q && tx_byte_valid_i;

  assign scl_hold = ((state_q == StWrAck) && byte_pend_q && !byte_ready_i) ||
                    ((state_q == StRdData) && load_pend_q);

  assign shift_en_o = (((state_q == StAddr) || (state_q == StWrData)) && scl_rise_i) ||
                      ((state_q == StRdData) && !load_pend_q && scl_fall_i);
  assign load_tx_o    = take_byte;
  assign byte_req_o   = take_byte;
  assign byte_valid_o = (state_q == StWrAck) && byte_pend_q && byte_ready_i;
  assign start_read_o = addr_ok && read_bit_i;
  assign end_xfer_o   = xfer_break && wr_xfer_q;
  assign end_read_o   = (xfer_break && rd_xfer_q) || rd_nack || rd_lost;

  assign scl_o = ~stretch_q;

  always_comb begin
    case (state_q)
      StAddrAck, StWrAck: sda_o = 1'b0;
      StRdData:           sda_o = load_pend_q ? 1'b1 : tx_bit_i;
      default:            sda_o = 1'b1;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q     <= StIdle;
      bit_cnt_q   <= '0;
      byte_done_q <= 1'b0;
      byte_pend_q <= 1'b0;
      load_pend_q <= 1'b0;
      host_ack_q  <= 1'b0;
      wr_xfer_q   <= 1'b0;
      rd_xfer_q   <= 1'b0;
      stretch_q   <= 1'b0;
    end else begin
      stretch_q <= scl_hold;
      if (scl_rise_i) begin
        bit_cnt_q  <= bit_cnt_q + 3'd1;
        host_ack_q <= host_ack_i;
        if (bit_cnt_q == 3'd7) begin
          byte_done_q <= 1'b1;
        end
      end
      if (byte_valid_o) begin
        byte_pend_q <= 1'b0;
      end
      if (take_byte) begin
        load_pend_q <= 1'b0;
      end

      if (xfer_break) begin
        state_q     <= (start_i && enable_i) ? StAddr : StIdle;
        bit_cnt_q   <= '0;
        byte_done_q <= 1'b0;
        byte_pend_q <= 1'b0;
        load_pend_q <= 1'b0;
        wr_xfer_q   <= 1'b0;
        rd_xfer_q   <= 1'b0;
      end else if (rd_nack || rd_lost) begin
        state_q     <= StIdle;
        rd_xfer_q   <= 1'b0;
        load_pend_q <= 1'b0;
      end else if (scl_fall_i) begin
        // ACK clock edges are not data bits
        bit_cnt_q   <= '0;
        byte_done_q <= 1'b0;
        case (state_q)
          StAddr: begin
            if (byte_done_q) begin
              state_q   <= addr_ok ? StAddrAck : StIdle;
              wr_xfer_q <= addr_ok && !read_bit_i;
              rd_xfer_q <= addr_ok && read_bit_i;
            end else begin
              bit_cnt_q <= bit_cnt_q;
            end
          end
          StWrData: begin
            if (byte_done_q) begin
              state_q     <= StWrAck;
              byte_pend_q <= 1'b1;
            end else begin
              bit_cnt_q <= bit_cnt_q;
            end
          end
          StRdData: begin
            if (byte_done_q) begin
              state_q <= StRdAck;
            end else begin
              bit_cnt_q <= bit_cnt_q;
            end
          end
          StAddrAck: begin
            state_q     <= rd_xfer_q ? StRdData : StWrData;
            load_pend_q <= rd_xfer_q;
          end
          StWrAck: state_q <= StWrData;
          StRdAck: begin
            // Host ACKed, fetch the next byte
            state_q     <= StRdData;
            load_pend_q <= 1'b1;
          end
          default: state_q <= StIdle;
        endcase
      end
    end
  end

endmodule

// ==== verilog/i2c_rx_packer.sv ====
// Packs received bytes into RX data words and posts the RX completion descriptor
`timescale 1ns/1ps

module i2c_rx_packer (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  logic                      byte_valid_i,
  input  logic                      end_xfer_i,
  input  i2c_standby_pkg::i2c_byte_t byte_i,
  output logic                      byte_ready_o,
  output logic                      data_wvalid_o,
  output logic                      desc_wvalid_o,
  input  logic                      data_wready_i,
  input  logic                      desc_wready_i,
  output i2c_standby_pkg::tti_word_t data_wdata_o,
  output i2c_standby_pkg::tti_word_t desc_wdata_o
);

  import i2c_standby_pkg::*;

  tti_word_t word_q;
  logic [1:0] lane_q;
  desc_len_t count_q;
  logic desc_pend_q;

  assign byte_ready_o = !data_wvalid_o && !desc_wvalid_o && !desc_pend_q;
  assign data_wdata_o = word_q;
  assign desc_wdata_o = {{(TtiDataWidth - DescLenWidth){1'b0}}, count_q};

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      word_q        <= '0;
      lane_q        <= '0;
      count_q       <= '0;
      desc_pend_q   <= 1'b0;
      data_wvalid_o <= 1'b0;
      desc_wvalid_o <= 1'b0;
    end else begin
      // Little-endian lanes
      if (byte_valid_i && byte_ready_o) begin
        word_q[8*lane_q +: 8] <= byte_i;
        lane_q  <= lane_q + 2'd1;
        count_q <= count_q + 1'b1;
        if (lane_q == 2'd3) begin
          data_wvalid_o <= 1'b1;
        end
      end
      if (end_xfer_i) begin
        // Flush a partial word, zero padded
        if (lane_q != 2'd0) begin
          data_wvalid_o <= 1'b1;
        end
        lane_q      <= '0;
        desc_pend_q <= (count_q != '0);
      end
      if (data_wvalid_o && data_wready_i) begin
        data_wvalid_o <= 1'b0;
        word_q        <= '0;
      end
      if (desc_pend_q && !data_wvalid_o && !desc_wvalid_o) begin
        desc_wvalid_o <= 1'b1;
        desc_pend_q   <= 1'b0;
      end
      if (desc_wvalid_o && desc_wready_i) begin
        desc_wvalid_o <= 1'b0;
        count_q       <= '0;
      end
    end
  end

endmodule

// ==== verilog/i2c_tx_unpacker.sv ====
// Takes the TX descriptor and data words and serves bytes, then FillByte past the count
`timescale 1ns/1ps

module i2c_tx_unpacker (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  logic                      start_read_i,
  input  logic                      byte_req_i,
  input  logic                      end_read_i,
  input  logic                      desc_rvalid_i,
  input  logic                      data_rvalid_i,
  input  i2c_standby_pkg::tti_word_t desc_rdata_i,
  input  i2c_standby_pkg::tti_word_t data_rdata_i,
  output logic                      desc_rready_o,
  output logic                      data_rready_o,
  output logic                      tx_byte_valid_o,
  output i2c_standby_pkg::i2c_byte_t tx_byte_o
);

  import i2c_standby_pkg::*;

  logic active_q;
  logic desc_wait_q;
  logic word_valid_q;
  logic [1:0] lane_q;
  desc_len_t remain_q;
  tti_word_t word_q;
  logic has_bytes;

  assign has_bytes       = (remain_q != '0);
  assign desc_rready_o   = desc_wait_q;
  assign data_rready_o   = active_q && !desc_wait_q && has_bytes && !word_valid_q;
  assign tx_byte_valid_o = active_q && !desc_wait_q && (!has_bytes || word_valid_q);
  assign tx_byte_o       = has_bytes ? word_q[8*lane_q +: 8] : FillByte;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      active_q     <= 1'b0;
      desc_wait_q  <= 1'b0;
      word_valid_q <= 1'b0;
      lane_q       <= '0;
      remain_q     <= '0;
    end else if (end_read_i) begin
      active_q     <= 1'b0;
      desc_wait_q  <= 1'b0;
      word_valid_q <= 1'b0;
    end else if (start_read_i) begin
      active_q     <= 1'b1;
      desc_wait_q  <= 1'b1;
      word_valid_q <= 1'b0;
      lane_q       <= '0;
      remain_q     <= '0;
    end else begin
      if (desc_rvalid_i && desc_wait_q) begin
        desc_wait_q <= 1'b0;
        remain_q    <= desc_rdata_i[DescLenWidth-1:0];
      end
      if (data_rvalid_i && data_rready_o) begin
        word_valid_q <= 1'b1;
      end
      if (byte_req_i && has_bytes && word_valid_q) begin
        remain_q <= remain_q - 1'b1;
        lane_q   <= lane_q + 2'd1;
        // Last lane used, next word needed
        if (lane_q == 2'd3) begin
          word_valid_q <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (data_rvalid_i && data_rready_o) begin
      word_q <= data_rdata_i;
    end
  end

endmodule

// ==== verilog/controller_standby_i2c.sv ====
// Standby I2C target top with bus pins and the four TTI queue ports
`timescale 1ns/1ps

module controller_standby_i2c (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  input  logic                       standby_en_i,
  input  logic                       ctrl_scl_i,
  input  logic                       ctrl_sda_i,
  output logic                       ctrl_scl_o,
  output logic                       ctrl_sda_o,
  // RX descriptor queue
  output logic                       tti_rx_desc_queue_wvalid_o,
  input  logic                       tti_rx_desc_queue_wready_i,
  output i2c_standby_pkg::tti_word_t tti_rx_desc_queue_wdata_o,
  // TX descriptor queue
  input  logic                       tti_tx_desc_queue_rvalid_i,
  output logic                       tti_tx_desc_queue_rready_o,
  input  i2c_standby_pkg::tti_word_t tti_tx_desc_queue_rdata_i,
  // RX data queue
  output logic                       tti_rx_queue_wvalid_o,
  input  logic                       tti_rx_queue_wready_i,
  output i2c_standby_pkg::tti_word_t tti_rx_queue_wdata_o,
  // TX data queue
  input  logic                       tti_tx_queue_rvalid_i,
  output logic                       tti_tx_queue_rready_o,
  input  i2c_standby_pkg::tti_word_t tti_tx_queue_rdata_i
);

  import i2c_standby_pkg::*;

  logic      bus_sda;
  logic      scl_rise;
  logic      scl_fall;
  logic      start_det;
  logic      stop_det;
  logic      shift_en;
  logic      load_tx;
  logic      addr_match;
  logic      read_bit;
  logic      tx_bit;
  logic      byte_valid;
  logic      byte_ready;
  logic      end_xfer;
  logic      start_read;
  logic      byte_req;
  logic      end_read;
  logic      tx_byte_valid;
  i2c_byte_t rx_byte;
  i2c_byte_t tx_byte;

  i2c_bus_monitor xi2c_bus_monitor (
    .clk_i,
    .arst_n_i,
    .scl_i     (ctrl_scl_i),
    .sda_i     (ctrl_sda_i),
    .sda_o     (bus_sda),
    .scl_rise_o(scl_rise),
    .scl_fall_o(scl_fall),
    .start_o   (start_det),
    .stop_o    (stop_det)
  );

  i2c_byte_shifter xi2c_byte_shifter (
    .clk_i,
    .arst_n_i,
    .shift_en_i  (shift_en),
    .sda_i       (bus_sda),
    .load_i      (load_tx),
    .tx_byte_i   (tx_byte),
    .rx_byte_o   (rx_byte),
    .addr_match_o(addr_match),
    .read_bit_o  (read_bit),
    .tx_bit_o    (tx_bit)
  );

  i2c_target_fsm xi2c_target_fsm (
    .clk_i,
    .arst_n_i,
    .enable_i       (standby_en_i),
    .sda_i          (bus_sda),
    .scl_rise_i     (scl_rise),
    .scl_fall_i     (scl_fall),
    .start_i        (start_det),
    .stop_i         (stop_det),
    .addr_match_i   (addr_match),
    .read_bit_i     (read_bit),
    .tx_bit_i       (tx_bit),
    .byte_ready_i   (byte_ready),
    .tx_byte_valid_i(tx_byte_valid),
    // ACK from the host is SDA held low
    .host_ack_i     (~bus_sda),
    .scl_o          (ctrl_scl_o),
    .sda_o          (ctrl_sda_o),
    .shift_en_o     (shift_en),
    .load_tx_o      (load_tx),
    .byte_valid_o   (byte_valid),
    .end_xfer_o     (end_xfer),
    .start_read_o   (start_read),
    .byte_req_o     (byte_req),
    .end_read_o     (end_read)
  );

  i2c_rx_packer xi2c_rx_packer (
    .clk_i,
    .arst_n_i,
    .byte_valid_i (byte_valid),
    .end_xfer_i   (end_xfer),
    .byte_i       (rx_byte),
    .byte_ready_o (byte_ready),
    .data_wvalid_o(tti_rx_queue_wvalid_o),
    .desc_wvalid_o(tti_rx_desc_queue_wvalid_o),
    .data_wready_i(tti_rx_queue_wready_i),
    .desc_wready_i(tti_rx_desc_queue_wready_i),
    .data_wdata_o (tti_rx_queue_wdata_o),
    .desc_wdata_o (tti_rx_desc_queue_wdata_o)
  );

  i2c_tx_unpacker xi2c_tx_unpacker (
    .clk_i,
    .arst_n_i,
    .start_read_i   (start_read),
    .byte_req_i     (byte_req),
    .end_read_i     (end_read),
    .desc_rvalid_i  (tti_tx_desc_queue_rvalid_i),
    .data_rvalid_i  (tti_tx_queue_rvalid_i),
    .desc_rdata_i   (tti_tx_desc_queue_rdata_i),
    .data_rdata_i   (tti_tx_queue_rdata_i),
    .desc_rready_o  (tti_tx_desc_queue_rready_o),
    .data_rready_o  (tti_tx_queue_rready_o),
    .tx_byte_valid_o(tx_byte_valid),
    .tx_byte_o      (tx_byte)
  );

endmodule

// ==== tb/i2c_host_tasks.svh ====
// Host-side I2C bus tasks for START, STOP, bit clocking with stretch waits, byte write and read
`ifndef I2C_HOST_TASKS_SVH
`define I2C_HOST_TASKS_SVH

task automatic idle_clocks(input int n);
  repeat (n) @(negedge clk_i);
endtask

// Target may hold SCL low
task automatic wait_scl_high();
  int cnt;
  cnt = 0;
  while (scl_line !== 1'b1) begin
    @(negedge clk_i);
    cnt++;
    if (cnt > StretchLimit) begin
      fail_now("SCL was held low by the target for too long");
    end
  end
endtask

// One bit period, returns the SDA level seen while SCL is high
task automatic clock_bit(input logic b, output logic seen);
  host_sda = b;
  idle_clocks(QuarterClks);
  host_scl = 1'b1;
  wait_scl_high();
  idle_clocks(QuarterClks);
  seen = sda_line;
  idle_clocks(QuarterClks);
  host_scl = 1'b0;
  idle_clocks(QuarterClks);
endtask

// Also serves as a repeated START
task automatic bus_start();
  host_sda = 1'b1;
  idle_clocks(QuarterClks);
  host_scl = 1'b1;
  wait_scl_high();
  idle_clocks(QuarterClks);
  host_sda = 1'b0;
  idle_clocks(QuarterClks);
  host_scl = 1'b0;
  idle_clocks(QuarterClks);
endtask

task automatic bus_stop();
  host_sda = 1'b0;
  idle_clocks(QuarterClks);
  host_scl = 1'b1;
  wait_scl_high();
  idle_clocks(QuarterClks);
  host_sda = 1'b1;
  idle_clocks(2 * QuarterClks);
endtask

task automatic send_byte(input i2c_byte_t b, output logic ack_level);
  logic seen;
  for (int i = 7; i >= 0; i--) begin
    clock_bit(b[i], seen);
  end
  // SDA released so the target can ACK
  clock_bit(1'b1, ack_level);
endtask

task automatic recv_byte(input logic nack, output i2c_byte_t b);
  logic seen;
  for (int i = 7; i >= 0; i--) begin
    clock_bit(1'b1, seen);
    b[i] = seen;
  end
  clock_bit(nack, seen);
endtask

`endif

// ==== tb/tb_controller_standby_i2c.sv ====
// Testbench with clock, reset, queue models, reference model, compare tasks and test sequence
`timescale 1ns/1ps

module tb_controller_standby_i2c;

  import i2c_standby_pkg::*;

  localparam int QuarterClks  = 10;
  localparam int StretchLimit = 4000;
  localparam int DrainLimit   = 4000;

  logic      clk_i;
  logic      arst_n_i;
  logic      standby_en;
  logic      host_scl;
  logic      host_sda;
  logic      scl_line;
  logic      sda_line;
  logic      dut_scl;
  logic      dut_sda;
  logic      rx_desc_wvalid;
  logic      rx_desc_wready;
  tti_word_t rx_desc_wdata;
  logic      tx_desc_rvalid;
  logic      tx_desc_rready;
  tti_word_t tx_desc_rdata;
  logic      rx_data_wvalid;
  logic      rx_data_wready;
  tti_word_t rx_data_wdata;
  logic      tx_data_rvalid;
  logic      tx_data_rready;
  tti_word_t tx_data_rdata;
  logic      tx_desc_taken;
  logic      tx_data_taken;
  int        rx_data_stall;
  int        rx_desc_stall;
  int        tx_desc_delay;
  int        tx_data_delay;
  int        stretch_cycles;

  tti_word_t exp_data[$];
  tti_word_t exp_desc[$];
  tti_word_t tx_desc_model[$];
  tti_word_t tx_data_model[$];

  // Open-drain bus
  assign scl_line = host_scl & dut_scl;
  assign sda_line = host_sda & dut_sda;

  controller_standby_i2c u_dut (
    .clk_i                     (clk_i),
    .arst_n_i                  (arst_n_i),
    .standby_en_i              (standby_en),
    .ctrl_scl_i                (scl_line),
    .ctrl_sda_i                (sda_line),
    .ctrl_scl_o                (dut_scl),
    .ctrl_sda_o                (dut_sda),
    .tti_rx_desc_queue_wvalid_o(rx_desc_wvalid),
    .tti_rx_desc_queue_wready_i(rx_desc_wready),
    .tti_rx_desc_queue_wdata_o (rx_desc_wdata),
    .tti_tx_desc_queue_rvalid_i(tx_desc_rvalid),
    .tti_tx_desc_queue_rready_o(tx_desc_rready),
    .tti_tx_desc_queue_rdata_i (tx_desc_rdata),
    .tti_rx_queue_wvalid_o     (rx_data_wvalid),
    .tti_rx_queue_wready_i     (rx_data_wready),
    .tti_rx_queue_wdata_o      (rx_data_wdata),
    .tti_tx_queue_rvalid_i     (tx_data_rvalid),
    .tti_tx_queue_rready_o     (tx_data_rready),
    .tti_tx_queue_rdata_i      (tx_data_rdata)
  );

  task automatic fail_now(input string why);
    $display("%s", why);
    $display("*** FAILED ***");
    $fatal(1);
  endtask

  task automatic check_word(input tti_word_t got, input tti_word_t exp, input string what);
    if (got !== exp) begin
      fail_now($sformatf("ERROR %0t ns: %s got %h expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_byte(input i2c_byte_t got, input i2c_byte_t exp, input string what);
    if (got !== exp) begin
      fail_now($sformatf("ERROR %0t ns: %s got %h expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_ack(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      fail_now($sformatf("ERROR %0t ns: %s got %b expected %b", $time, what, got, exp));
    end
  endtask

  `include "i2c_host_tasks.svh"

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // RX writes checked against the model as they happen
  always @(posedge clk_i) begin
    if (rx_data_wvalid && rx_data_wready) begin
      if (exp_data.size() == 0) begin
        fail_now("The DUT wrote an RX data word when none was expected");
      end else begin
        check_word(rx_data_wdata, exp_data.pop_front(), "RX data word");
      end
    end
    if (rx_desc_wvalid && rx_desc_wready) begin
      if (exp_desc.size() == 0) begin
        fail_now("The DUT wrote an RX descriptor when none was expected");
      end else begin
        check_word(rx_desc_wdata, exp_desc.pop_front(), "RX descriptor");
      end
    end
    // SCL held low by the DUT after the host released it
    if (host_scl && !dut_scl) begin
      stretch_cycles++;
    end
    tx_desc_taken <= tx_desc_rvalid && tx_desc_rready;
    tx_data_taken <= tx_data_rvalid && tx_data_rready;
  end

  // Queue side, wready stalls and rvalid delays of random length
  always @(negedge clk_i) begin
    if (arst_n_i) begin
      if (rx_data_stall > 0) begin
        rx_data_stall--;
      end else if (($urandom % 32) == 0) begin
        rx_data_stall = $urandom % 600;
      end
      rx_data_wready = (rx_data_stall == 0);
      if (rx_desc_stall > 0) begin
        rx_desc_stall--;
      end else if (($urandom % 32) == 0) begin
        rx_desc_stall = $urandom % 600;
      end
      rx_desc_wready = (rx_desc_stall == 0);
      if (tx_desc_taken) begin
        void'(tx_desc_model.pop_front());
        tx_desc_rvalid = 1'b0;
      end
      if (tx_data_taken) begin
        void'(tx_data_model.pop_front());
        tx_data_rvalid = 1'b0;
      end
      // Delays run only while the DUT asks for a word
      if (!tx_desc_rvalid && tx_desc_rready && tx_desc_model.size() > 0) begin
        if (tx_desc_delay == 0) begin
          tx_desc_rvalid = 1'b1;
          tx_desc_rdata  = tx_desc_model[0];
          tx_desc_delay  = $urandom % 100;
        end else begin
          tx_desc_delay--;
        end
      end
      if (!tx_data_rvalid && tx_data_rready && tx_data_model.size() > 0) begin
        if (tx_data_delay == 0) begin
          tx_data_rvalid = 1'b1;
          tx_data_rdata  = tx_data_model[0];
          tx_data_delay  = $urandom % 400;
        end else begin
          tx_data_delay--;
        end
      end
    end
  end

  task automatic write_xfer(input int len, input logic with_stop);
    i2c_byte_t b;
    tti_word_t w;
    logic      ack_level;
    w = '0;
    bus_start();
    send_byte({TargetAddr, 1'b0}, ack_level);
    check_ack(ack_level, 1'b0, "write address ACK");
    for (int i = 0; i < len; i++) begin
      b = i2c_byte_t'($urandom);
      // Little-endian lanes, zero padded tail
      w[8 * (i % 4) +: 8] = b;
      if ((i % 4) == 3 || i == len - 1) begin
        exp_data.push_back(w);
        w = '0;
      end
      send_byte(b, ack_level);
      check_ack(ack_level, 1'b0, "write data ACK");
    end
    exp_desc.push_back(tti_word_t'(len));
    if (with_stop) begin
      bus_stop();
    end
  endtask

  task automatic read_xfer(input int count, input int extra);
    tti_word_t words[$];
    tti_word_t d;
    i2c_byte_t got;
    i2c_byte_t exp_b;
    logic      ack_level;
    int        nbytes;
    // Upper descriptor bits are don't care
    d = tti_word_t'($urandom);
    d[DescLenWidth-1:0] = count[DescLenWidth-1:0];
    tx_desc_model.push_back(d);
    for (int i = 0; i < count; i += 4) begin
      words.push_back(tti_word_t'($urandom));
      tx_data_model.push_back(words[$]);
    end
    nbytes = (count + extra > 0) ? count + extra : 1;
    bus_start();
    send_byte({TargetAddr, 1'b1}, ack_level);
    check_ack(ack_level, 1'b0, "read address ACK");
    for (int i = 0; i < nbytes; i++) begin
      recv_byte(i == nbytes - 1, got);
      exp_b = (i < count) ? words[i / 4][8 * (i % 4) +: 8] : FillByte;
      check_byte(got, exp_b, "read byte");
    end
    bus_stop();
    if (tx_desc_model.size() != 0 || tx_data_model.size() != 0) begin
      fail_now("The DUT left TX queue words unread after a read transfer");
    end
  endtask

  task automatic nacked_addr(input i2c_byte_t addr_byte, input string what);
    logic ack_level;
    bus_start();
    send_byte(addr_byte, ack_level);
    check_ack(ack_level, 1'b1, what);
    bus_stop();
  endtask

  task automatic wait_rx_drained();
    int cnt;
    cnt = 0;
    while (exp_data.size() != 0 || exp_desc.size() != 0) begin
      @(negedge clk_i);
      cnt++;
      if (cnt > DrainLimit) begin
        fail_now("Expected RX words never arrived from the DUT");
      end
    end
  endtask

  initial begin
    void'($urandom(1909));
    arst_n_i       = 1'b0;
    standby_en     = 1'b1;
    host_scl       = 1'b1;
    host_sda       = 1'b1;
    rx_desc_wready = 1'b0;
    rx_data_wready = 1'b0;
    tx_desc_rvalid = 1'b0;
    tx_desc_rdata  = '0;
    tx_data_rvalid = 1'b0;
    tx_data_rdata  = '0;
    tx_desc_taken  = 1'b0;
    tx_data_taken  = 1'b0;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    arst_n_i = 1'b1;
    check_ack(rx_data_wvalid, 1'b0, "RX data wvalid after reset");
    check_ack(rx_desc_wvalid, 1'b0, "RX descriptor wvalid after reset");
    check_ack(tx_data_rready, 1'b0, "TX data rready after reset");
    check_ack(tx_desc_rready, 1'b0, "TX descriptor rready after reset");
    check_ack(dut_scl, 1'b1, "SCL output after reset");
    check_ack(dut_sda, 1'b1, "SDA output after reset");
    idle_clocks(10);

    for (int t = 0; t < 8; t++) begin
      write_xfer(1 + ($urandom % 9), 1'b1);
      wait_rx_drained();
    end
    for (int t = 0; t < 8; t++) begin
      read_xfer($urandom % 9, $urandom % 3);
    end
    nacked_addr({7'h0D, 1'b0}, "wrong write address NACK");
    nacked_addr({7'h0D, 1'b1}, "wrong read address NACK");

    @(negedge clk_i);
    standby_en = 1'b0;
    nacked_addr({TargetAddr, 1'b0}, "disabled address NACK");
    @(negedge clk_i);
    standby_en = 1'b1;

    // Write, then repeated START into a read
    write_xfer(1 + ($urandom % 9), 1'b0);
    read_xfer(1 + ($urandom % 8), 1);
    wait_rx_drained();
    idle_clocks(100);

    if (stretch_cycles == 0) begin
      fail_now("The DUT never stretched SCL under queue back-pressure");
    end else begin
      $display("*** PASSED ***");
      $finish;
    end
  end

endmodule

// ==== sim.f ====
+incdir+tb
verilog/i2c_standby_pkg.sv
verilog/i2c_bus_monitor.sv
verilog/i2c_byte_shifter.sv
verilog/i2c_target_fsm.sv
verilog/i2c_rx_packer.sv
verilog/i2c_tx_unpacker.sv
verilog/controller_standby_i2c.sv
tb/tb_controller_standby_i2c.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_controller_standby_i2c
SEED      ?= 1909
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary --timing -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) +verilator+seed+$(SEED)

lint:
	$(VERILATOR) --lint-only -Wall --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)
